//--- sdspi_chk_pkg.sv
// SD SPI response checker definitions

package sdspi_chk_pkg;

    // Register offset and reply word widths
    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;

    // Command step counter and reply length minus one
    typedef logic [7:0] cnt_t;
    typedef logic [5:0] len_t;

    // How the reply at the current step is judged
    typedef enum logic [2:0] {
        PASSTHROUGH,
        VALIDATE,
        ERROR,
        FINAL,
        CAUSE_ERROR,
        CAUSE_VALIDATION,
        CHECK_IF_DATA
    } resp_class_t;

    // Register map of the driver
    typedef enum logic [ADDR_W-1:0] {
        BEGINNING_OFFSET       = 8'h00,
        BUFFER_OFFSET          = 8'h04,
        CHANGE_BAUDRATE_OFFSET = 8'h08,
        CMD0_OFFSET            = 8'h0C,
        CMD8_OFFSET            = 8'h10,
        CMD59_OFFSET           = 8'h14,
        CMD58_OFFSET           = 8'h18,
        ACMD41_OFFSET          = 8'h1C
    } cmd_offset_t;

    ////////////////////////////////////////
    // Expected card replies
    ////////////////////////////////////////
    localparam logic [DATA_W-1:0] R1_IDLE             = 32'h0000_0001;
    localparam logic [DATA_W-1:0] R1_READY            = 32'h0000_0000;
    localparam logic [DATA_W-1:0] CMD8_ECHO           = 32'h0000_00AA;
    localparam logic [DATA_W-1:0] CMD8_R7             = 32'h0100_0001;
    localparam logic [DATA_W-1:0] CMD58_OCR           = 32'h0100_FF80;
    localparam logic [DATA_W-1:0] DATA_TOKEN_ACCEPTED = 32'h0000_0005;
    localparam logic [DATA_W-1:0] IDLE_LINE           = 32'hFFFF_FFFF;

    // Steps of the transparent block transfers
    localparam cnt_t WR_BUSY_STEP      = 8'd198;
    localparam cnt_t WR_TOKEN_STEP     = 8'd68;
    localparam cnt_t RD_TIMEOUT_STEP   = 8'd130;
    localparam cnt_t RD_DATA_LAST_STEP = 8'd127;

endpackage

//--- sdspi_expect_table.sv
// SD SPI expected response table
`timescale 1ns/1ns

module sdspi_expect_table #(
    parameter logic [sdspi_chk_pkg::ADDR_W-1:0] RW_MAX_OFFSET = 8'h7F
) (
    input  logic                               req_i,
    input  logic                               we_i,
    input  logic [sdspi_chk_pkg::ADDR_W-1:0]   addr_i,
    input  sdspi_chk_pkg::cnt_t                cnt_cmd_i,
    input  sdspi_chk_pkg::len_t                len_cmd_i,
    output sdspi_chk_pkg::resp_class_t         exp_class_o,
    output logic [sdspi_chk_pkg::DATA_W-1:0]   exp_data_o,
    output logic [sdspi_chk_pkg::DATA_W-1:0]   exp_mask_o
);

    import sdspi_chk_pkg::*;

    // Transparent read/write region starts right after ACMD41
    localparam logic [ADDR_W-1:0] RW_MIN_OFFSET = 8'h20;

    localparam logic [DATA_W-1:0] OCR_TOP_MASK   = 32'hFF00_0000;
    localparam logic [DATA_W-1:0] TOKEN_MASK     = 32'h0000_001F;
    localparam logic [DATA_W-1:0] BUSY_LINE_MASK = 32'h0000_0001;

    cmd_offset_t       offset;
    logic              in_rw_region;
    logic [DATA_W-1:0] default_mask;

    assign offset = cmd_offset_t'(addr_i);

    assign in_rw_region = req_i && (addr_i >= RW_MIN_OFFSET) && (addr_i <= RW_MAX_OFFSET);

    // Keep the low len_cmd_i+1 bits, saturates at a full word
    assign default_mask = ~(({DATA_W{1'b1}} << len_cmd_i) << 1);

    ////////////////////////////////////////
    // Command sequence lookup
    ////////////////////////////////////////
    always_comb begin
        exp_class_o = PASSTHROUGH;
        exp_data_o  = '0;
        exp_mask_o  = default_mask;

        case (offset)
            BEGINNING_OFFSET, BUFFER_OFFSET: begin
                if (cnt_cmd_i == 8'd1) begin
                    exp_class_o = VALIDATE;
                end
            end
            CHANGE_BAUDRATE_OFFSET: begin
                // Baud-rate register is write only
                exp_class_o = we_i ? VALIDATE : ERROR;
            end
            CMD0_OFFSET, CMD59_OFFSET: begin
                exp_class_o = FINAL;
                exp_data_o  = R1_IDLE;
            end
            CMD8_OFFSET: begin
                if (cnt_cmd_i == 8'd2) begin
                    exp_class_o = CAUSE_ERROR;
                    exp_data_o  = CMD8_R7;
                end else begin
                    exp_class_o = FINAL;
                    exp_data_o  = CMD8_ECHO;
                end
            end
            CMD58_OFFSET: begin
                if (cnt_cmd_i == 8'd2) begin
                    // Only the top byte of the OCR matters
                    exp_class_o = CAUSE_ERROR;
                    exp_data_o  = CMD58_OCR;
                    exp_mask_o  = OCR_TOP_MASK;
                end else begin
                    exp_class_o = VALIDATE;
                end
            end
            ACMD41_OFFSET: begin
                // Polling loop repeats every eight steps
                if (cnt_cmd_i[2:0] == 3'd2) begin
                    exp_class_o = CAUSE_VALIDATION;
                    exp_data_o  = R1_READY;
                end else if (cnt_cmd_i == 8'd1) begin
                    exp_class_o = CAUSE_ERROR;
                    exp_data_o  = R1_READY;
                end
            end
            default: begin
                if (in_rw_region && we_i) begin
                    case (cnt_cmd_i)
                        WR_BUSY_STEP: begin
                            exp_class_o = CAUSE_ERROR;
                            exp_data_o  = R1_READY;
                        end
                        WR_TOKEN_STEP: begin
                            exp_class_o = CAUSE_ERROR;
                            exp_data_o  = DATA_TOKEN_ACCEPTED;
                            exp_mask_o  = TOKEN_MASK;
                        end
                        8'd1: begin
                            exp_class_o = ERROR;
                        end
                        default: begin
                            // Card releases the line once busy ends
                            if (cnt_cmd_i > 8'd1 && cnt_cmd_i < WR_TOKEN_STEP) begin
                                exp_class_o = CAUSE_VALIDATION;
                                exp_data_o  = IDLE_LINE;
                                exp_mask_o  = BUSY_LINE_MASK;
                            end
                        end
                    endcase
                end else if (in_rw_region) begin
                    case (cnt_cmd_i)
                        RD_TIMEOUT_STEP: begin
                            exp_class_o = CAUSE_ERROR;
                            exp_data_o  = R1_READY;
                        end
                        8'd1: begin
                            exp_class_o = ERROR;
                        end
                        default: begin
                            if (cnt_cmd_i > 8'd1 && cnt_cmd_i <= RD_DATA_LAST_STEP) begin
                                exp_class_o = CHECK_IF_DATA;
                            end
                        end
                    endcase
                end
            end
        endcase
    end

endmodule

//--- sdspi_expect_reg.sv
// SD SPI expectation register
`timescale 1ns/1ns

module sdspi_expect_reg (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               spi_clk_i,
    input  sdspi_chk_pkg::resp_class_t         exp_class_i,
    input  logic [sdspi_chk_pkg::DATA_W-1:0]   exp_data_i,
    input  logic [sdspi_chk_pkg::DATA_W-1:0]   exp_mask_i,
    output sdspi_chk_pkg::resp_class_t         held_class_o,
    output logic [sdspi_chk_pkg::DATA_W-1:0]   held_data_o,
    output logic [sdspi_chk_pkg::DATA_W-1:0]   held_mask_o
);

    import sdspi_chk_pkg::*;

    logic spi_clk_q;
    logic spi_rise;

    // Rising edge of the sampled SPI clock
    assign spi_rise = spi_clk_i && !spi_clk_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            spi_clk_q <= 1'b0;
        end else begin
            spi_clk_q <= spi_clk_i;
        end
    end

    ////////////////////////////////////////
    // Expectation hold
    ////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            held_class_o <= PASSTHROUGH;
        end else if (spi_rise) begin
            held_class_o <= exp_class_i;
        end
    end

    // Compare word and mask taken on the same edge
    always_ff @(posedge clk_i) begin
        if (spi_rise) begin
            held_data_o <= exp_data_i;
            held_mask_o <= exp_mask_i;
        end
    end

endmodule

//--- sdspi_verdict.sv
// SD SPI reply verdict and bus response
`timescale 1ns/1ns

module sdspi_verdict #(
    parameter int ID_W = 5
) (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               req_i,
    input  logic                               en_write_i,
    input  logic                               start_bit_i,
    input  logic                               last_bit_i,
    input  logic [ID_W-1:0]                    aid_i,
    input  logic [sdspi_chk_pkg::DATA_W-1:0]   data_i,
    input  sdspi_chk_pkg::resp_class_t         held_class_i,
    input  logic [sdspi_chk_pkg::DATA_W-1:0]   held_data_i,
    input  logic [sdspi_chk_pkg::DATA_W-1:0]   held_mask_i,
    output logic                               done_o,
    output logic                               gnt_o,
    output logic                               rvalid_o,
    output logic                               err_o,
    output logic [ID_W-1:0]                    rid_o,
    output logic [sdspi_chk_pkg::DATA_W-1:0]   rdata_o
);

    import sdspi_chk_pkg::*;

    logic last_bit_q;
    logic read_phase_q;
    logic fire;
    logic match;
    logic correct;
    logic error;
    logic valid_q;
    logic err_q;

    // First cycle of a last-bit pulse while the card is talking
    assign fire  = last_bit_i && !last_bit_q && !en_write_i;
    assign match = ((data_i ^ held_data_i) & held_mask_i) == '0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            last_bit_q   <= 1'b0;
            read_phase_q <= 1'b0;
        end else begin
            last_bit_q <= last_bit_i;
            if (start_bit_i) begin
                read_phase_q <= 1'b1;
            end else if (last_bit_i) begin
                read_phase_q <= 1'b0;
            end
        end
    end

    ////////////////////////////////////////
    // Verdict
    ////////////////////////////////////////
    always_comb begin
        correct = 1'b0;
        error   = 1'b0;
        if (fire) begin
            case (held_class_i)
                FINAL: begin
                    correct = match;
                    error   = !match;
                end
                CAUSE_ERROR:      error   = !match;
                CAUSE_VALIDATION: correct = match;
                VALIDATE:         correct = 1'b1;
                ERROR:            error   = 1'b1;
                // Data seen only if a start bit came in
                CHECK_IF_DATA:    correct = read_phase_q;
                default: begin
                    correct = 1'b0;
                    error   = 1'b0;
                end
            endcase
        end
    end

    assign done_o = correct || error;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            valid_q <= done_o;
            err_q   <= error;
        end
    end

    always_ff @(posedge clk_i) begin
        rid_o <= aid_i;
    end

    // Bus response
    assign gnt_o    = done_o || !req_i;
    assign rvalid_o = valid_q;
    assign err_o    = err_q;
    assign rdata_o  = data_i;

endmodule

//--- sdspi_resp_checker.sv
// SD SPI response checker top
`timescale 1ns/1ns

module sdspi_resp_checker #(
    parameter int                               ID_W          = 5,
    parameter logic [sdspi_chk_pkg::ADDR_W-1:0] RW_MAX_OFFSET = 8'h7F
) (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               spi_clk_i,
    input  logic                               req_i,
    input  logic                               we_i,
    input  logic                               en_write_i,
    input  logic                               start_bit_i,
    input  logic                               last_bit_i,
    input  logic [sdspi_chk_pkg::ADDR_W-1:0]   addr_i,
    input  logic [ID_W-1:0]                    aid_i,
    input  logic [sdspi_chk_pkg::DATA_W-1:0]   data_i,
    input  sdspi_chk_pkg::cnt_t                cnt_cmd_i,
    input  sdspi_chk_pkg::len_t                len_cmd_i,
    output logic                               gnt_o,
    output logic                               rvalid_o,
    output logic                               err_o,
    output logic                               done_o,
    output logic [ID_W-1:0]                    rid_o,
    output logic [sdspi_chk_pkg::DATA_W-1:0]   rdata_o
);

    import sdspi_chk_pkg::*;

    resp_class_t       exp_class;
    logic [DATA_W-1:0] exp_data;
    logic [DATA_W-1:0] exp_mask;
    resp_class_t       held_class;
    logic [DATA_W-1:0] held_data;
    logic [DATA_W-1:0] held_mask;

    ////////////////////////////////////////
    // Lookup, hold, judge
    ////////////////////////////////////////
    sdspi_expect_table #(
        .RW_MAX_OFFSET (RW_MAX_OFFSET)
    ) sdspi_expect_table_i (
        .req_i       (req_i),
        .we_i        (we_i),
        .addr_i      (addr_i),
        .cnt_cmd_i   (cnt_cmd_i),
        .len_cmd_i   (len_cmd_i),
        .exp_class_o (exp_class),
        .exp_data_o  (exp_data),
        .exp_mask_o  (exp_mask)
    );

    sdspi_expect_reg sdspi_expect_reg_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .spi_clk_i    (spi_clk_i),
        .exp_class_i  (exp_class),
        .exp_data_i   (exp_data),
        .exp_mask_i   (exp_mask),
        .held_class_o (held_class),
        .held_data_o  (held_data),
        .held_mask_o  (held_mask)
    );

    sdspi_verdict #(
        .ID_W (ID_W)
    ) sdspi_verdict_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (req_i),
        .en_write_i   (en_write_i),
        .start_bit_i  (start_bit_i),
        .last_bit_i   (last_bit_i),
        .aid_i        (aid_i),
        .data_i       (data_i),
        .held_class_i (held_class),
        .held_data_i  (held_data),
        .held_mask_i  (held_mask),
        .done_o       (done_o),
        .gnt_o        (gnt_o),
        .rvalid_o     (rvalid_o),
        .err_o        (err_o),
        .rid_o        (rid_o),
        .rdata_o      (rdata_o)
    );

endmodule

//--- tb_sdspi_resp_checker.sv
// SD SPI response checker testbench
`timescale 1ns/1ns

module tb_sdspi_resp_checker;

    localparam int CLK_HALF     = 50;
    localparam int DRIVE_DLY    = 10;
    localparam int ID_W         = 5;
    localparam int DONE_TIMEOUT = 8;
    localparam int QUIET_CYCLES = 4;
    localparam int WATCHDOG_NS  = 400000;

    // Register offsets and card replies
    localparam logic [7:0]  OFS_BAUD   = 8'h08;
    localparam logic [7:0]  OFS_CMD0   = 8'h0C;
    localparam logic [7:0]  OFS_CMD8   = 8'h10;
    localparam logic [7:0]  OFS_ACMD41 = 8'h1C;
    localparam logic [7:0]  OFS_RW     = 8'h40;
    localparam logic [31:0] REPLY_R7   = 32'h0100_0001;

    logic            clk;
    logic            rst;
    logic            spi_clk;
    logic            req;
    logic            we;
    logic            en_write;
    logic            start_bit;
    logic            last_bit;
    logic [7:0]      addr;
    logic [ID_W-1:0] aid;
    logic [31:0]     data;
    logic [7:0]      cnt;
    logic [5:0]      len;
    logic            gnt;
    logic            rvalid;
    logic            err;
    logic            done;
    logic [ID_W-1:0] rid;
    logic [31:0]     rdata;

    logic [15:0]     lfsr;
    int              errors;
    int              checks;
    int              tests;

    sdspi_resp_checker sdspi_resp_checker_i (
        .clk_i       (clk),
        .rst_i       (rst),
        .spi_clk_i   (spi_clk),
        .req_i       (req),
        .we_i        (we),
        .en_write_i  (en_write),
        .start_bit_i (start_bit),
        .last_bit_i  (last_bit),
        .addr_i      (addr),
        .aid_i       (aid),
        .data_i      (data),
        .cnt_cmd_i   (cnt),
        .len_cmd_i   (len),
        .gnt_o       (gnt),
        .rvalid_o    (rvalid),
        .err_o       (err),
        .done_o      (done),
        .rid_o       (rid),
        .rdata_o     (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    initial begin
        #WATCHDOG_NS;
        $display("Simulation stopped by the watchdog timer");
        $display("Done: errors found");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        lfsr_next = state >> 1;
        if (state[0]) begin
            lfsr_next = lfsr_next ^ 16'hB400;
        end
    endfunction

    // Shifts in the LFSR output bit by bit
    task automatic draw_bits(input int count, output logic [31:0] value);
        int i;
        value = '0;
        for (i = 0; i < count; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests++;
        if (errors == errors_before) begin
            $display("test %s ok", name);
        end else begin
            $display("test %s: %0d error(s)", name, errors - errors_before);
        end
    endtask

    // Sets the access, then one low and one high SPI clock cycle
    task automatic load_expect(input logic write, input logic [7:0] offset,
                               input logic [7:0] step, input logic [5:0] length);
        req     = 1'b1;
        we      = write;
        addr    = offset;
        cnt     = step;
        len     = length;
        spi_clk = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
        spi_clk = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic pulse_start();
        start_bit = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        start_bit = 1'b0;
    endtask

    // Last-bit pulse that must end in a bus response
    task automatic answered_reply(input logic [31:0] value, input logic exp_err);
        int              waited;
        logic            seen;
        logic [ID_W-1:0] fire_aid;
        logic [31:0]     id_bits;
        draw_bits(ID_W, id_bits);
        aid      = id_bits[ID_W-1:0];
        data     = value;
        last_bit = 1'b1;
        waited   = 0;
        seen     = 1'b0;
        fire_aid = '0;
        while (!seen && waited < DONE_TIMEOUT) begin
            @(negedge clk);
            check_value("rdata_o", rdata, value);
            if (done) begin
                seen     = 1'b1;
                fire_aid = aid;
                check_value("gnt_o", 32'(gnt), 32'd1);
            end else begin
                waited++;
            end
            @(posedge clk);
            #DRIVE_DLY;
        end
        if (!seen) begin
            errors++;
            $display("Timeout at %0t ns: done_o never rose for reply 0x%0h", $time, value);
        end else begin
            // New id so the registered copy can be told apart
            draw_bits(ID_W, id_bits);
            aid = id_bits[ID_W-1:0];
            // Pulse still high, only its first cycle may judge
            @(negedge clk);
            check_value("rvalid_o", 32'(rvalid), 32'd1);
            check_value("err_o", 32'(err), 32'(exp_err));
            check_value("rid_o", 32'(rid), 32'(fire_aid));
            check_value("done_o", 32'(done), 32'd0);
            @(posedge clk);
            #DRIVE_DLY;
        end
        last_bit = 1'b0;
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    // Last-bit pulse that must leave the bus quiet
    task automatic ignored_reply(input logic [31:0] value);
        int i;
        data     = value;
        last_bit = 1'b1;
        for (i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
            check_value("done_o", 32'(done), 32'd0);
            check_value("rdata_o", rdata, value);
            if (i == 0) begin
                check_value("gnt_o", 32'(gnt), 32'(!req));
            end else begin
                check_value("rvalid_o", 32'(rvalid), 32'd0);
            end
            @(posedge clk);
            #DRIVE_DLY;
            last_bit = 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // Tests
    ////////////////////////////////////////
    task automatic reset_state();
        int err_start;
        err_start = errors;
        @(negedge clk);
        check_value("rvalid_o", 32'(rvalid), 32'd0);
        check_value("err_o", 32'(err), 32'd0);
        check_value("done_o", 32'(done), 32'd0);
        check_value("gnt_o", 32'(gnt), 32'd1);
        @(posedge clk);
        #DRIVE_DLY;
        report_test("reset", err_start);
    endtask

    task automatic cmd0_idle();
        int          err_start;
        logic [31:0] wrong;
        err_start = errors;
        load_expect(1'b0, OFS_CMD0, 8'd1, 6'd7);
        answered_reply(32'h0000_0001, 1'b0);
        draw_bits(32, wrong);
        // Low byte must differ from the idle R1
        if (wrong[7:0] == 8'h01) begin
            wrong[7] = 1'b1;
        end
        answered_reply(wrong, 1'b1);
        report_test("cmd0", err_start);
    endtask

    task automatic cmd8_check();
        int          err_start;
        logic [31:0] flip;
        err_start = errors;
        load_expect(1'b0, OFS_CMD8, 8'd2, 6'd31);
        ignored_reply(REPLY_R7);
        draw_bits(32, flip);
        if (flip == 32'd0) begin
            flip = 32'd1;
        end
        answered_reply(REPLY_R7 ^ flip, 1'b1);
        // Echo byte only, upper bits masked off
        load_expect(1'b0, OFS_CMD8, 8'd3, 6'd7);
        answered_reply({flip[23:0], 8'hAA}, 1'b0);
        report_test("cmd8", err_start);
    endtask

    task automatic acmd41_poll();
        int          err_start;
        logic [31:0] bits;
        err_start = errors;
        load_expect(1'b0, OFS_ACMD41, 8'd2, 6'd7);
        answered_reply(32'h0000_0000, 1'b0);
        ignored_reply(32'h0000_0001);
        load_expect(1'b0, OFS_ACMD41, 8'd1, 6'd7);
        ignored_reply(32'h0000_0000);
        draw_bits(8, bits);
        if (bits[7:0] == 8'h00) begin
            bits[6] = 1'b1;
        end
        answered_reply(bits, 1'b1);
        report_test("acmd41", err_start);
    endtask

    task automatic transparent_rw();
        int          err_start;
        logic [31:0] bits;
        err_start = errors;
        draw_bits(32, bits);
        load_expect(1'b0, OFS_RW, 8'd5, 6'd7);
        ignored_reply(bits);
        pulse_start();
        answered_reply(~bits, 1'b0);
        // Token check keeps only the low five bits
        load_expect(1'b1, OFS_RW, 8'd68, 6'd7);
        ignored_reply(32'h0000_00E5);
        answered_reply(32'h0000_000B, 1'b1);
        report_test("transparent", err_start);
    endtask

    task automatic baudrate_rw();
        int          err_start;
        logic [31:0] bits;
        err_start = errors;
        draw_bits(32, bits);
        load_expect(1'b1, OFS_BAUD, 8'd0, 6'd7);
        answered_reply(bits, 1'b0);
        load_expect(1'b0, OFS_BAUD, 8'd0, 6'd7);
        answered_reply(bits, 1'b1);
        en_write = 1'b1;
        ignored_reply(~bits);
        en_write = 1'b0;
        report_test("baudrate", err_start);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        lfsr      = 16'd7;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        rst       = 1'b1;
        spi_clk   = 1'b0;
        req       = 1'b0;
        we        = 1'b0;
        en_write  = 1'b0;
        start_bit = 1'b0;
        last_bit  = 1'b0;
        addr      = 8'h00;
        aid       = '0;
        data      = 32'd0;
        cnt       = 8'd0;
        len       = 6'd7;

        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rst = 1'b0;

        reset_state();
        cmd0_idle();
        cmd8_check();
        acmd41_poll();
        transparent_rw();
        baudrate_rw();

        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- filelist.f
sdspi_chk_pkg.sv
sdspi_expect_table.sv
sdspi_expect_reg.sv
sdspi_verdict.sv
sdspi_resp_checker.sv
tb_sdspi_resp_checker.sv

//--- Makefile
# Verilator build and run for the SD SPI response checker

VERILATOR  ?= verilator
TOP        ?= tb_sdspi_resp_checker
RTL_TOP    ?= sdspi_resp_checker
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --timescale 1ns/1ns
LINT_FLAGS ?= --lint-only --timescale 1ns/1ns
PASS_MSG   ?= Done: no errors
RTL_SRCS   ?= sdspi_chk_pkg.sv sdspi_expect_table.sv sdspi_expect_reg.sv \
              sdspi_verdict.sv sdspi_resp_checker.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Fails unless the pass line shows up in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)
